// File: files.f
+incdir+logic
logic/vtp_pkg.sv
logic/vtp_heap_store.sv
logic/vtp_decode.sv
logic/vtp_l1_tlb.sv
logic/vtp_execute.sv
logic/vtp_result.sv
logic/vtp_shim_top.sv
verification/vtp_shim_sva.sv
verification/tb_vtp_shim.sv

// File: logic/vtp_decode.sv
/*
 * VTP decode stage.
 * Accepts requests, allocates heap tags and computes flow control.
 */
`timescale 1ns/1ns
`include "vtp_macros.svh"

module vtp_decode (
    input logic clk,
    input logic reset,
    input logic req_valid,
    input vtp_pkg::mem_req_t req,
    output logic not_full,
    input logic l1_ready,
    input logic rsp_pending,
    input logic out_almost_full,
    input logic free_en,
    input vtp_pkg::req_tag_t free_tag,
    output vtp_pkg::stage_t stage,
    output logic ctx_wen,
    output vtp_pkg::req_ctx_t ctx_wdata,
    output vtp_pkg::va_page_t page_wdata,
    output vtp_pkg::req_tag_t wtag
);
    import vtp_pkg::*;

    // One bit per heap slot, set when free
    logic [`VTP_MAX_REQS-1:0] free_map;
    req_tag_t alloc_tag;
    logic accept;

    // Lowest free tag wins
    always_comb
    begin
        alloc_tag = '0;
        for (int i = `VTP_MAX_REQS - 1; i >= 0; i--)
        begin
            if (free_map[i])
            begin
                alloc_tag = req_tag_t'(i);
            end
        end
    end

    // Pending service answers hold off new work so bubbles appear
    assign not_full = (|free_map) && l1_ready && !rsp_pending && !out_almost_full;
    assign accept = req_valid && not_full;

    // ==================================================
    // Heap write at acceptance
    // ==================================================
    assign ctx_wen = accept;
    assign wtag = alloc_tag;
    assign page_wdata = req.addr[`VTP_CL_ADDR_BITS-1:`VTP_OFFSET_BITS];
    assign ctx_wdata.meta = req.meta;
    assign ctx_wdata.offset = req.addr[`VTP_OFFSET_BITS-1:0];
    assign ctx_wdata.virt = req.virt;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            free_map <= '1;
        end
        else
        begin
            // Retiring tag and new tag never collide
            if (free_en)
            begin
                free_map[free_tag] <= 1'b1;
            end
            if (accept)
            begin
                free_map[alloc_tag] <= 1'b0;
            end
        end
    end

    // Stage record for execute
    always_ff @(posedge clk)
    begin
        stage.valid <= accept;
        stage.virt <= req.virt;
        stage.va_page <= page_wdata;
        stage.tag <= alloc_tag;
        if (reset)
        begin
            stage.valid <= 1'b0;
        end
    end

endmodule

// File: logic/vtp_execute.sv
/*
 * VTP execute stage.
 * Carries requests through the L1 lookup, resolves hits, sends
 * misses to the service and merges answers into empty slots.
 */
`timescale 1ns/1ns
`include "vtp_macros.svh"

module vtp_execute (
    input logic clk,
    input logic reset,
    input vtp_pkg::stage_t stage_in,
    input logic out_almost_full,
    output vtp_pkg::va_page_t l1_page,
    input logic l1_hit,
    input vtp_pkg::pa_page_t l1_hit_pa,
    output logic svc_lookup_en,
    output vtp_pkg::svc_req_t svc_req,
    input logic svc_rsp_valid,
    input vtp_pkg::svc_rsp_t svc_rsp,
    output logic rsp_pending,
    output vtp_pkg::resolved_t resolved
);
    import vtp_pkg::*;

    localparam int PTR_BITS = $clog2(`VTP_MAX_REQS);
    localparam int CNT_BITS = PTR_BITS + 1;

    // Slot 1 is stage_in itself
    stage_t slot2;
    stage_t slot3;

    logic pick_main;
    logic miss;
    logic miss_q;
    svc_req_t svc_q;

    // Answer FIFO
    svc_rsp_t rsp_mem [`VTP_MAX_REQS];
    logic [PTR_BITS-1:0] rsp_wr_ptr;
    logic [PTR_BITS-1:0] rsp_rd_ptr;
    logic [CNT_BITS-1:0] rsp_count;
    logic rsp_deq;
    logic rsp_deq_q;
    svc_rsp_t rsp_q;

    // L1 read starts from slot 1
    assign l1_page = stage_in.va_page;

    always_ff @(posedge clk)
    begin
        slot2 <= stage_in;
        slot3 <= slot2;
        if (reset)
        begin
            slot2.valid <= 1'b0;
            slot3.valid <= 1'b0;
        end
    end

    // ==================================================
    // Slot 3 decision
    // ==================================================
    assign pick_main = slot3.valid && (!slot3.virt || l1_hit);
    assign miss = slot3.valid && slot3.virt && !l1_hit;

    // Service lookup leaves one edge after the miss is noted
    always_ff @(posedge clk)
    begin
        miss_q <= miss;
        svc_q.va_page <= slot3.va_page;
        svc_q.tag <= slot3.tag;
        svc_lookup_en <= miss_q;
        svc_req <= svc_q;
        if (reset)
        begin
            miss_q <= 1'b0;
            svc_lookup_en <= 1'b0;
        end
    end

    // ==================================================
    // Service answers
    // ==================================================
    assign rsp_pending = (rsp_count != '0);

    // An empty slot 2 becomes an empty slot 3 on the next edge
    assign rsp_deq = rsp_pending && !slot2.valid && !out_almost_full;

    always_ff @(posedge clk)
    begin
        if (svc_rsp_valid)
        begin
            rsp_mem[rsp_wr_ptr] <= svc_rsp;
        end
        rsp_q <= rsp_mem[rsp_rd_ptr];
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rsp_wr_ptr <= '0;
            rsp_rd_ptr <= '0;
            rsp_count <= '0;
            rsp_deq_q <= 1'b0;
        end
        else
        begin
            rsp_wr_ptr <= rsp_wr_ptr + PTR_BITS'(svc_rsp_valid);
            rsp_rd_ptr <= rsp_rd_ptr + PTR_BITS'(rsp_deq);
            rsp_count <= rsp_count + CNT_BITS'(svc_rsp_valid) - CNT_BITS'(rsp_deq);
            rsp_deq_q <= rsp_deq;
        end
    end

    // Main path or the injected answer, never both
    always_ff @(posedge clk)
    begin
        resolved.valid <= pick_main || rsp_deq_q;
        resolved.tag <= pick_main ? slot3.tag : rsp_q.tag;
        resolved.pa_page <= pick_main ? l1_hit_pa : rsp_q.pa_page;
        resolved.from_svc <= rsp_deq_q;
        resolved.l1_hit <= pick_main && slot3.virt;
        if (reset)
        begin
            resolved.valid <= 1'b0;
        end
    end

endmodule

// File: logic/vtp_heap_store.sv
/*
 * Tag-indexed request heap.
 * Holds one payload per outstanding request until it retires.
 */
`timescale 1ns/1ns
`include "vtp_macros.svh"

module vtp_heap_store #(
    parameter type entry_t = logic
) (
    input logic clk,
    input logic wen,
    input vtp_pkg::req_tag_t wtag,
    input entry_t wdata,
    input vtp_pkg::req_tag_t rtag,
    output entry_t rdata
);
    import vtp_pkg::*;

    // One slot per tag
    entry_t mem [`VTP_MAX_REQS];

    // Written when decode allocates the tag
    always_ff @(posedge clk)
    begin
        if (wen)
        begin
            mem[wtag] <= wdata;
        end
    end

    // Result reads in the same cycle it sees the tag
    assign rdata = mem[rtag];

endmodule

// File: logic/vtp_l1_tlb.sv
/*
 * Direct-mapped L1 TLB.
 * Two-cycle lookup, single write port shared by reset walk,
 * invalidation and fill, in that priority.
 */
`timescale 1ns/1ns
`include "vtp_macros.svh"

module vtp_l1_tlb (
    input logic clk,
    input logic reset,
    output logic ready,
    input vtp_pkg::va_page_t lookup_page,
    output logic hit,
    output vtp_pkg::pa_page_t hit_pa,
    input vtp_pkg::l1_fill_t fill,
    input logic inval_valid,
    input logic [`VTP_VA_PAGE_BITS-1:0] inval_page
);
    import vtp_pkg::*;

    localparam int IDX_BITS = $clog2(`VTP_L1_ENTRIES);
    localparam int TAG_BITS = `VTP_VA_PAGE_BITS - IDX_BITS;

    typedef logic [IDX_BITS-1:0] l1_idx_t;

    typedef struct packed {
        logic valid;
        logic [TAG_BITS-1:0] tag;
        pa_page_t pa;
    } l1_entry_t;

    l1_entry_t tlb_mem [`VTP_L1_ENTRIES];

    // Lookup pipeline
    va_page_t page_q1;
    va_page_t page_q2;
    l1_entry_t entry_q;

    // Reset walk
    logic walk_busy;
    l1_idx_t walk_idx;

    // Write port
    logic wen;
    l1_idx_t waddr;
    l1_entry_t wdata;

    // ==================================================
    // Write port arbitration
    // ==================================================
    always_comb
    begin
        wen = fill.valid;
        waddr = fill.va_page[IDX_BITS-1:0];
        wdata.valid = 1'b1;
        wdata.tag = fill.va_page[`VTP_VA_PAGE_BITS-1:IDX_BITS];
        wdata.pa = fill.pa_page;

        if (walk_busy)
        begin
            wen = 1'b1;
            waddr = walk_idx;
            wdata.valid = 1'b0;
        end
        else if (inval_valid)
        begin
            // Host invalidation beats a fill
            wen = 1'b1;
            waddr = inval_page[IDX_BITS-1:0];
            wdata.valid = 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wen)
        begin
            tlb_mem[waddr] <= wdata;
        end
    end

    // ==================================================
    // Lookup takes the address at one edge and the entry at the next
    // ==================================================
    always_ff @(posedge clk)
    begin
        page_q1 <= lookup_page;
        page_q2 <= page_q1;
        entry_q <= tlb_mem[page_q1[IDX_BITS-1:0]];
    end

    assign hit = entry_q.valid && (entry_q.tag == page_q2[`VTP_VA_PAGE_BITS-1:IDX_BITS]);
    assign hit_pa = entry_q.pa;

    // Walk every entry invalid after reset
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            walk_busy <= 1'b1;
            walk_idx <= '0;
        end
        else if (walk_busy)
        begin
            walk_idx <= walk_idx + 1'b1;
            if (walk_idx == l1_idx_t'(`VTP_L1_ENTRIES - 1))
            begin
                walk_busy <= 1'b0;
            end
        end
    end

    assign ready = !walk_busy;

endmodule

// File: logic/vtp_macros.svh
/*
 * VTP shim widths and depths.
 * Cache-line addressing with 4 KB pages and a 64-entry L1.
 */
`ifndef VTP_MACROS_SVH
`define VTP_MACROS_SVH

// Cache-line address and its split at the 4 KB boundary
`define VTP_CL_ADDR_BITS 42
`define VTP_OFFSET_BITS 6
`define VTP_VA_PAGE_BITS 36
`define VTP_PA_PAGE_BITS 30

// Request metadata carried unchanged
`define VTP_META_BITS 16

// Outstanding requests and heap depth
`define VTP_MAX_REQS 16

// Direct-mapped L1 TLB depth
`define VTP_L1_ENTRIES 64

`endif

// File: logic/vtp_pkg.sv
/*
 * VTP shim shared types.
 * Request, pipeline stage, service and L1 fill records.
 */
`include "vtp_macros.svh"

package vtp_pkg;

    typedef logic [`VTP_VA_PAGE_BITS-1:0] va_page_t;
    typedef logic [`VTP_PA_PAGE_BITS-1:0] pa_page_t;
    typedef logic [`VTP_OFFSET_BITS-1:0] offset_t;
    typedef logic [$clog2(`VTP_MAX_REQS)-1:0] req_tag_t;

    // Memory request as seen on both ends of the shim
    typedef struct packed {
        logic [`VTP_META_BITS-1:0] meta;
        logic [`VTP_CL_ADDR_BITS-1:0] addr;
        logic virt;
    } mem_req_t;

    // Heap record of a request while it is translated
    typedef struct packed {
        logic [`VTP_META_BITS-1:0] meta;
        offset_t offset;
        logic virt;
    } req_ctx_t;

    // Pipeline slot contents
    typedef struct packed {
        logic valid;
        logic virt;
        va_page_t va_page;
        req_tag_t tag;
    } stage_t;

    typedef struct packed {
        va_page_t va_page;
        req_tag_t tag;
    } svc_req_t;

    typedef struct packed {
        pa_page_t pa_page;
        req_tag_t tag;
    } svc_rsp_t;

    // Execute hands result one record per slot
    typedef struct packed {
        logic valid;
        req_tag_t tag;
        pa_page_t pa_page;
        logic from_svc;
        logic l1_hit;
    } resolved_t;

    typedef struct packed {
        logic valid;
        va_page_t va_page;
        pa_page_t pa_page;
    } l1_fill_t;

endpackage

// File: logic/vtp_result.sv
/*
 * VTP result stage.
 * Rebuilds the outgoing request from the heap, retires its tag
 * and refills the L1 with service translations.
 */
`timescale 1ns/1ns
`include "vtp_macros.svh"

module vtp_result (
    input logic clk,
    input logic reset,
    input vtp_pkg::resolved_t resolved,
    output vtp_pkg::req_tag_t rtag,
    input vtp_pkg::req_ctx_t ctx,
    input vtp_pkg::va_page_t va_page,
    output logic out_valid,
    output vtp_pkg::mem_req_t out_req,
    output logic free_en,
    output vtp_pkg::req_tag_t free_tag,
    output vtp_pkg::l1_fill_t fill
);
    import vtp_pkg::*;

    va_page_t out_page;
    logic fill_pend;
    va_page_t fill_va;
    pa_page_t fill_pa;

    assign rtag = resolved.tag;

    // Translated page is zero-extended, physical page kept as stored
    assign out_page = ctx.virt ? va_page_t'(resolved.pa_page) : va_page;

    // ==================================================
    // Outgoing request and tag release
    // ==================================================
    always_ff @(posedge clk)
    begin
        out_valid <= resolved.valid;
        out_req.meta <= ctx.meta;
        out_req.addr <= {out_page, ctx.offset};
        out_req.virt <= 1'b0;
        free_en <= resolved.valid;
        free_tag <= resolved.tag;
        if (reset)
        begin
            out_valid <= 1'b0;
            free_en <= 1'b0;
        end
    end

    // L1 fill trails the output by one edge
    always_ff @(posedge clk)
    begin
        fill_pend <= resolved.valid && resolved.from_svc;
        fill_va <= va_page;
        fill_pa <= resolved.pa_page;
        fill.valid <= fill_pend;
        fill.va_page <= fill_va;
        fill.pa_page <= fill_pa;
        if (reset)
        begin
            fill_pend <= 1'b0;
            fill.valid <= 1'b0;
        end
    end

endmodule

// File: logic/vtp_shim_top.sv
/*
 * VTP translation shim top level.
 * Decode, execute with L1 TLB, result and the two request heaps.
 */
`timescale 1ns/1ns
`include "vtp_macros.svh"

module vtp_shim_top (
    input logic clk,
    input logic reset,
    input logic req_valid,
    input vtp_pkg::mem_req_t req,
    output logic not_full,
    output logic out_valid,
    output vtp_pkg::mem_req_t out_req,
    input logic out_almost_full,
    output logic svc_lookup_en,
    output vtp_pkg::svc_req_t svc_req,
    input logic svc_rsp_valid,
    input vtp_pkg::svc_rsp_t svc_rsp,
    input logic inval_valid,
    input logic [`VTP_VA_PAGE_BITS-1:0] inval_page
);
    import vtp_pkg::*;

    // Decode side
    stage_t stage;
    logic ctx_wen;
    req_ctx_t ctx_wdata;
    va_page_t page_wdata;
    req_tag_t wtag;
    logic free_en;
    req_tag_t free_tag;

    // Execute and L1
    logic l1_ready;
    va_page_t l1_page;
    logic l1_hit;
    pa_page_t l1_hit_pa;
    logic rsp_pending;
    resolved_t resolved;

    // Result side
    req_tag_t rtag;
    req_ctx_t ctx_rdata;
    va_page_t page_rdata;
    l1_fill_t fill;

    vtp_decode decode0 (
        .clk, .reset, .req_valid, .req, .not_full, .l1_ready, .rsp_pending,
        .out_almost_full, .free_en, .free_tag, .stage, .ctx_wen, .ctx_wdata,
        .page_wdata, .wtag
    );

    vtp_heap_store #(.entry_t(req_ctx_t)) ctx_heap (
        .clk, .wen(ctx_wen), .wtag, .wdata(ctx_wdata), .rtag, .rdata(ctx_rdata)
    );

    vtp_heap_store #(.entry_t(va_page_t)) page_heap (
        .clk, .wen(ctx_wen), .wtag, .wdata(page_wdata), .rtag, .rdata(page_rdata)
    );

    vtp_l1_tlb l1 (
        .clk, .reset, .ready(l1_ready), .lookup_page(l1_page), .hit(l1_hit),
        .hit_pa(l1_hit_pa), .fill, .inval_valid, .inval_page
    );

    vtp_execute execute0 (
        .clk, .reset, .stage_in(stage), .out_almost_full, .l1_page, .l1_hit,
        .l1_hit_pa, .svc_lookup_en, .svc_req, .svc_rsp_valid, .svc_rsp,
        .rsp_pending, .resolved
    );

    vtp_result result0 (
        .clk, .reset, .resolved, .rtag, .ctx(ctx_rdata), .va_page(page_rdata),
        .out_valid, .out_req, .free_en, .free_tag, .fill
    );

endmodule

// File: verification/tb_vtp_shim.sv
/*
 * Testbench for the VTP translation shim.
 * Translation service model, scoreboard keyed by metadata
 * and directed tests for pass-through, miss, hit, invalidation and burst.
 */
`timescale 1ns/1ns
`include "vtp_macros.svh"

module tb_vtp_shim;
    import vtp_pkg::*;

    // Reset walk, five short tests and a 40-request burst with slow misses
    localparam int TIMEOUT_CYCLES = 5000;
    localparam int SVC_MIN_DELAY = 3;
    localparam int SVC_MAX_DELAY = 20;
    localparam int BURST_LEN = 40;

    // Two pages sharing L1 index 6'h09 with different tags
    localparam va_page_t PAGE_A = 36'h1_2345_6789;
    localparam va_page_t PAGE_B = 36'h3_2345_6789;

    logic clk;
    logic reset;
    logic req_valid;
    mem_req_t req;
    logic not_full;
    logic out_valid;
    mem_req_t out_req;
    logic out_almost_full;
    logic svc_lookup_en;
    svc_req_t svc_req;
    logic svc_rsp_valid;
    svc_rsp_t svc_rsp;
    logic inval_valid;
    logic [`VTP_VA_PAGE_BITS-1:0] inval_page;

    integer seed = 45;
    int cycle_count = 0;
    int error_count = 0;
    int check_count = 0;
    int accept_cycle = 0;
    string test_name = "reset walk";

    // Scoreboard with one entry per metadata value
    logic [`VTP_CL_ADDR_BITS-1:0] exp_addr [0:65535];
    bit exp_live [0:65535];
    int out_cycle [0:65535];

    // Service model with one outstanding lookup per heap tag
    bit svc_busy [`VTP_MAX_REQS];
    int svc_due [`VTP_MAX_REQS];
    va_page_t svc_page [`VTP_MAX_REQS];
    int lookup_count = 0;
    va_page_t last_lookup;

    vtp_shim_top dut0 (
        .clk, .reset, .req_valid, .req, .not_full, .out_valid, .out_req,
        .out_almost_full, .svc_lookup_en, .svc_req, .svc_rsp_valid, .svc_rsp,
        .inval_valid, .inval_page
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Cycle counter and run limit
    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Run stopped after %0d cycles, test %s never finished",
                     cycle_count, test_name);
            $display("TB FAILED");
            $finish;
        end
    end

    // ==================================================
    // Helpers
    // ==================================================
    // Low page bits XOR a fixed pattern give the zero-extended physical page
    function automatic logic [`VTP_CL_ADDR_BITS-1:0] translated_addr(
        input logic [`VTP_CL_ADDR_BITS-1:0] addr
    );
        pa_page_t pa;
        pa = addr[`VTP_OFFSET_BITS +: `VTP_PA_PAGE_BITS] ^ 30'h155AA;
        return {va_page_t'(pa), addr[`VTP_OFFSET_BITS-1:0]};
    endfunction

    task automatic report_value(input string what, input logic [63:0] expected,
                                input logic [63:0] actual);
        error_count++;
        $display("** Error %s: %s expected 0x%0h, actual 0x%0h",
                 test_name, what, expected, actual);
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // Compare one output against the scoreboard
    task automatic check_out(input mem_req_t got);
        int key;
        key = got.meta;
        check_count++;
        if (!exp_live[key])
        begin
            error_count++;
            $display("Output with metadata 0x%0h in test %s was not expected or came twice",
                     key, test_name);
        end
        else
        begin
            if (got.addr !== exp_addr[key])
                report_value($sformatf("meta 0x%0h address", key), exp_addr[key], got.addr);
            if (got.virt !== 1'b0)
                report_value($sformatf("meta 0x%0h virtual flag", key), 0, got.virt);
            exp_live[key] = 1'b0;
            out_cycle[key] = cycle_count;
        end
    endtask

    // Record lookups and outputs where they are stable
    always @(negedge clk)
    begin
        if (!reset && svc_lookup_en)
        begin
            lookup_count++;
            last_lookup = svc_req.va_page;
            if (svc_busy[svc_req.tag])
            begin
                error_count++;
                $display("Lookup for tag %0d sent while the last one is unanswered",
                         svc_req.tag);
            end
            svc_busy[svc_req.tag] = 1'b1;
            svc_page[svc_req.tag] = svc_req.va_page;
            svc_due[svc_req.tag] = cycle_count + SVC_MIN_DELAY
                + ({$random(seed)} % (SVC_MAX_DELAY - SVC_MIN_DELAY + 1));
        end
        if (!reset && out_valid)
        begin
            check_out(out_req);
        end
    end

    // At most one answer per cycle with the lowest due tag first
    task automatic drive_answer();
        bit found;
        found = 1'b0;
        svc_rsp_valid = 1'b0;
        for (int t = 0; t < `VTP_MAX_REQS; t++)
        begin
            if (!found && svc_busy[t] && svc_due[t] <= cycle_count)
            begin
                found = 1'b1;
                svc_busy[t] = 1'b0;
                svc_rsp_valid = 1'b1;
                svc_rsp.tag = req_tag_t'(t);
                svc_rsp.pa_page = svc_page[t][`VTP_PA_PAGE_BITS-1:0] ^ 30'h155AA;
            end
        end
    endtask

    initial
    begin
        svc_rsp_valid = 1'b0;
        svc_rsp = '0;
        forever
        begin
            step();
            drive_answer();
        end
    end

    // Hold a request until not_full lets it in
    task automatic send_req(input logic [15:0] meta, input logic [`VTP_CL_ADDR_BITS-1:0] addr,
                            input logic virt);
        bit taken;
        taken = 1'b0;
        req.meta = meta;
        req.addr = addr;
        req.virt = virt;
        req_valid = 1'b1;
        exp_addr[meta] = virt ? translated_addr(addr) : addr;
        exp_live[meta] = 1'b1;
        while (!taken)
        begin
            @(negedge clk);
            if (not_full)
            begin
                taken = 1'b1;
                accept_cycle = cycle_count + 1;
            end
            step();
        end
        req_valid = 1'b0;
    endtask

    task automatic wait_out(input logic [15:0] meta);
        while (exp_live[meta])
        begin
            step();
        end
    endtask

    // ==================================================
    // Directed tests
    // ==================================================
    task automatic reset_walk_test();
        int low_cycles;
        low_cycles = 0;
        repeat (8) step();
        reset = 1'b0;
        @(negedge clk);
        while (!not_full)
        begin
            low_cycles++;
            @(negedge clk);
        end
        step();
        if (low_cycles != `VTP_L1_ENTRIES)
            report_value("not_full low cycles after reset", `VTP_L1_ENTRIES, low_cycles);
    endtask

    task automatic physical_test();
        int lookups;
        test_name = "physical";
        lookups = lookup_count;
        send_req(16'h0001, 42'h1234_5678_9AB, 1'b0);
        wait_out(16'h0001);
        if (out_cycle[16'h0001] - accept_cycle != 4)
            report_value("latency", 4, out_cycle[16'h0001] - accept_cycle);
        repeat (4) step();
        if (lookup_count != lookups)
            report_value("lookups", 0, lookup_count - lookups);
    endtask

    task automatic miss_test();
        int lookups;
        test_name = "miss";
        lookups = lookup_count;
        send_req(16'h0002, {PAGE_A, 6'h15}, 1'b1);
        wait_out(16'h0002);
        if (lookup_count - lookups != 1)
            report_value("lookups", 1, lookup_count - lookups);
        if (last_lookup !== PAGE_A)
            report_value("lookup page", PAGE_A, last_lookup);
    endtask

    task automatic hit_test();
        int lookups;
        test_name = "hit";
        // Fill lands two edges after the miss leaves
        repeat (4) step();
        lookups = lookup_count;
        send_req(16'h0003, {PAGE_A, 6'h2A}, 1'b1);
        wait_out(16'h0003);
        if (out_cycle[16'h0003] - accept_cycle != 4)
            report_value("latency", 4, out_cycle[16'h0003] - accept_cycle);
        if (lookup_count != lookups)
            report_value("lookups on hit", 0, lookup_count - lookups);
        // Same index with another tag
        lookups = lookup_count;
        send_req(16'h0004, {PAGE_B, 6'h01}, 1'b1);
        wait_out(16'h0004);
        if (lookup_count - lookups != 1)
            report_value("lookups on tag conflict", 1, lookup_count - lookups);
        if (last_lookup !== PAGE_B)
            report_value("lookup page", PAGE_B, last_lookup);
    endtask

    task automatic inval_test();
        int lookups;
        test_name = "invalidate";
        repeat (4) step();
        lookups = lookup_count;
        send_req(16'h0005, {PAGE_B, 6'h3F}, 1'b1);
        wait_out(16'h0005);
        if (lookup_count != lookups)
            report_value("lookups before invalidation", 0, lookup_count - lookups);
        inval_valid = 1'b1;
        inval_page = PAGE_B;
        step();
        inval_valid = 1'b0;
        lookups = lookup_count;
        send_req(16'h0006, {PAGE_B, 6'h00}, 1'b1);
        wait_out(16'h0006);
        if (lookup_count - lookups != 1)
            report_value("lookups after invalidation", 1, lookup_count - lookups);
    endtask

    // A request left waiting must not get in while downstream is nearly full
    task automatic hold_back_pressure();
        int low_cycles;
        low_cycles = 0;
        out_almost_full = 1'b1;
        req.meta = 16'hFFFF;
        req.addr = '0;
        req.virt = 1'b0;
        req_valid = 1'b1;
        repeat (12)
        begin
            @(negedge clk);
            if (!not_full)
                low_cycles++;
            step();
        end
        req_valid = 1'b0;
        out_almost_full = 1'b0;
        if (low_cycles != 12)
            report_value("not_full low cycles under back-pressure", 12, low_cycles);
    endtask

    task automatic burst_test();
        va_page_t page;
        logic [`VTP_CL_ADDR_BITS-1:0] addr;
        test_name = "burst";
        // Small page pool so hits, misses and index conflicts mix
        for (int i = 0; i < BURST_LEN; i++)
        begin
            page = {27'h0_3F0A, 9'($random(seed))};
            addr = {page, 6'($random(seed))};
            send_req(16'h0100 + 16'(i), addr, ($random(seed) % 4) != 0);
            if (i == BURST_LEN / 2)
                hold_back_pressure();
        end
        for (int i = 0; i < BURST_LEN; i++)
        begin
            wait_out(16'h0100 + 16'(i));
        end
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial
    begin
        reset = 1'b1;
        req_valid = 1'b0;
        req = '0;
        out_almost_full = 1'b0;
        inval_valid = 1'b0;
        inval_page = '0;
        reset_walk_test();
        physical_test();
        miss_test();
        hit_test();
        inval_test();
        burst_test();
        repeat (10) step();
        $display("Outputs checked: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, dut0.execute0.sva0.fail_count);
        if (error_count == 0 && dut0.execute0.sva0.fail_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// File: verification/vtp_shim_sva.sv
/*
 * Assertions on the VTP execute stage.
 * Slot sharing, lookup source and quiet outputs in reset.
 */
`timescale 1ns/1ns

module vtp_shim_sva (
    input logic clk,
    input logic reset,
    input vtp_pkg::stage_t slot3,
    input logic pick_main,
    input logic rsp_deq_q,
    input logic svc_lookup_en,
    input vtp_pkg::resolved_t resolved
);

    // Failed assertions so far
    int fail_count = 0;

    // Main-path item and injected answer never in the same slot
    slot_share_a: assert property (@(posedge clk) disable iff (reset)
        !(pick_main && rsp_deq_q))
        else
        begin
            fail_count++;
            $error("Main-path item and service answer share a slot");
        end

    // A physical item in slot 3 never turns into a lookup two edges on
    phys_lookup_a: assert property (@(posedge clk) disable iff (reset)
        (slot3.valid && !slot3.virt) |-> ##2 !svc_lookup_en)
        else
        begin
            fail_count++;
            $error("Service lookup sent for a physical request");
        end

    // Registered outputs clear one edge into reset
    reset_quiet_a: assert property (@(posedge clk)
        reset |=> (!svc_lookup_en && !resolved.valid))
        else
        begin
            fail_count++;
            $error("Execute outputs active during reset");
        end

endmodule

bind vtp_execute vtp_shim_sva sva0 (
    .clk, .reset, .slot3, .pick_main, .rsp_deq_q, .svc_lookup_en, .resolved
);
